// ==== verilog/branchPkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types, RV32 opcode constants
// and the two-bit counter states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package branchPkg;

    typedef logic [31:0] addrT;
    typedef logic [31:0] instrT;
    typedef logic [6:0]  opcodeT;
    typedef logic [2:0]  funct3T;

    // Saturating predictor states
    // The MSB set predicts taken
    typedef enum logic [1:0] {
        STRONGLY_NOT_TAKEN = 2'b00,
        WEAKLY_NOT_TAKEN   = 2'b01,
        WEAKLY_TAKEN       = 2'b10,
        STRONGLY_TAKEN     = 2'b11
    } counterT;

    // Major opcodes
    localparam opcodeT OP_BRANCH = 7'b1100011;
    localparam opcodeT OP_JAL    = 7'b1101111;

    // Branch conditions
    localparam funct3T F3_BEQ = 3'b000;
    localparam funct3T F3_BNE = 3'b001;

    // addi x0, x0, 0
    localparam instrT NOP_INSTR = 32'h0000_0013;

    localparam addrT INSTR_BYTES = 32'd4;

endpackage

// ==== verilog/branchTargetBuffer.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped branch target buffer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module branchTargetBuffer #(
    parameter int BTB_ENTRIES = 32
) (
    input  logic            clk,
    input  logic            reset,
    input  branchPkg::addrT lookupPc_i,
    output logic            hit_o,
    output branchPkg::addrT target_o,
    output logic            isJump_o,
    input  logic            we_i,
    input  branchPkg::addrT writePc_i,
    input  branchPkg::addrT writeTarget_i,
    input  logic            writeJump_i
);

    import branchPkg::*;

    localparam int INDEX_BITS = $clog2(BTB_ENTRIES);

    logic [BTB_ENTRIES-1:0] validBits;
    addrT                   targets [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] jumpBits;

    logic [INDEX_BITS-1:0] lookupIndex;
    logic [INDEX_BITS-1:0] writeIndex;

    // Word index, byte offset dropped
    assign lookupIndex = lookupPc_i[INDEX_BITS+1:2];
    assign writeIndex  = writePc_i[INDEX_BITS+1:2];

    assign hit_o    = validBits[lookupIndex];
    assign target_o = targets[lookupIndex];
    assign isJump_o = jumpBits[lookupIndex];

    always_ff @(posedge clk) begin
        if (reset) begin
            validBits <= '0;
        end else if (we_i) begin
            validBits[writeIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            targets[writeIndex]  <= writeTarget_i;
            jumpBits[writeIndex] <= writeJump_i;
        end
    end

    // Updates come from execute, whose PC came out of fetch
    aWriteAligned : assert property (@(posedge clk) disable iff (reset)
        we_i |-> (writePc_i[1:0] == 2'b00));

endmodule

// ==== verilog/gshareTable.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Gshare predictor: history register
// and two-bit counter table
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module gshareTable #(
    parameter int GHR_BITS = 5
) (
    input  logic                   clk,
    input  logic                   reset,
    input  branchPkg::addrT        fetchPc_i,
    output logic [GHR_BITS-1:0]    readIndex_o,
    output branchPkg::counterT     counter_o,
    input  logic                   shiftEn_i,
    input  logic                   shiftBit_i,
    input  logic                   clearHistory_i,
    input  logic                   updateEn_i,
    input  logic [GHR_BITS-1:0]    updateIndex_i,
    input  logic                   taken_i
);

    import branchPkg::*;

    localparam int TABLE_SIZE = 2 ** GHR_BITS;

    logic [GHR_BITS-1:0] history;
    counterT             counters [TABLE_SIZE];
    counterT             oldCount;

    assign readIndex_o = fetchPc_i[GHR_BITS+1:2] ^ history;
    assign counter_o   = counters[readIndex_o];
    assign oldCount    = counters[updateIndex_i];

    // Clear has priority over a shift
    always_ff @(posedge clk) begin
        if (reset || clearHistory_i) begin
            history <= '0;
        end else if (shiftEn_i) begin
            history <= {history[GHR_BITS-2:0], shiftBit_i};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                counters[i] <= WEAKLY_NOT_TAKEN;
            end
        end else if (updateEn_i) begin
            // Saturate at both ends
            if (taken_i && oldCount != STRONGLY_TAKEN) begin
                counters[updateIndex_i] <= counterT'(oldCount + 2'd1);
            end else if (!taken_i && oldCount != STRONGLY_NOT_TAKEN) begin
                counters[updateIndex_i] <= counterT'(oldCount - 2'd1);
            end
        end
    end

    // A mispredict squashes the fetch that would have shifted
    aShiftNotClear : assert property (@(posedge clk) disable iff (reset)
        !(shiftEn_i && clearHistory_i));

endmodule

// ==== verilog/fetchStage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch PC register and next-PC mux
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fetchStage #(
    parameter branchPkg::addrT RESET_PC = '0
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall_i,
    input  logic            mispredict_i,
    input  branchPkg::addrT redirectPc_i,
    input  logic            predictTaken_i,
    input  branchPkg::addrT predictTarget_i,
    output branchPkg::addrT pc_o
);

    import branchPkg::*;

    addrT nextPc;

    // Redirect from execute, then the prediction, then sequential
    always_comb begin
        if (mispredict_i) begin
            nextPc = redirectPc_i;
        end else if (predictTaken_i) begin
            nextPc = predictTarget_i;
        end else begin
            nextPc = pc_o + INSTR_BYTES;
        end
    end

    // A redirect must not be lost to a stall
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_o <= RESET_PC;
        end else if (mispredict_i || !stall_i) begin
            pc_o <= nextPc;
        end
    end

endmodule

// ==== verilog/decodeStage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode register with flush to NOP,
// B-type and J-type immediates
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module decodeStage #(
    parameter int GHR_BITS = 5
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall_i,
    input  logic                flush_i,
    input  branchPkg::instrT    instr_i,
    input  branchPkg::addrT     pc_i,
    input  logic                predTaken_i,
    input  logic [GHR_BITS-1:0] phtIndex_i,
    output branchPkg::opcodeT   opcode_o,
    output branchPkg::funct3T   funct3_o,
    output branchPkg::addrT     imm_o,
    output branchPkg::addrT     pc_o,
    output logic                predTaken_o,
    output logic [GHR_BITS-1:0] phtIndex_o
);

    import branchPkg::*;

    instrT instrD;
    addrT  immB;
    addrT  immJ;

    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            instrD      <= NOP_INSTR;
            predTaken_o <= 1'b0;
        end else if (!stall_i) begin
            instrD      <= instr_i;
            predTaken_o <= predTaken_i;
        end
    end

    // Prediction info rides along, ignored once the word is a NOP
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pc_o       <= pc_i;
            phtIndex_o <= phtIndex_i;
        end
    end

    assign opcode_o = instrD[6:0];
    assign funct3_o = instrD[14:12];

    assign immB = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
    assign immJ = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};

    assign imm_o = (opcode_o == OP_JAL) ? immJ : immB;

endmodule

// ==== verilog/branchResolve.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute register, branch outcome,
// mispredict and predictor updates
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module branchResolve #(
    parameter int BTB_ENTRIES = 32,
    parameter int GHR_BITS    = 5
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                bubble_i,
    input  branchPkg::opcodeT   opcode_i,
    input  branchPkg::funct3T   funct3_i,
    input  branchPkg::addrT     imm_i,
    input  branchPkg::addrT     pc_i,
    input  logic                predTaken_i,
    input  logic [GHR_BITS-1:0] phtIndex_i,
    input  logic                zero_i,
    output logic                mispredict_o,
    output branchPkg::addrT     redirectPc_o,
    output logic                btbWe_o,
    output branchPkg::addrT     btbPc_o,
    output branchPkg::addrT     btbTarget_o,
    output logic                btbJump_o,
    output logic                phtWe_o,
    output logic [GHR_BITS-1:0] phtIndex_o,
    output logic                phtTaken_o
);

    import branchPkg::*;

    opcodeT              opcodeE;
    funct3T              funct3E;
    addrT                immE;
    addrT                pcE;
    logic                predTakenE;
    logic [GHR_BITS-1:0] phtIndexE;

    logic isBranch;
    logic isJal;
    logic branchTaken;
    addrT targetPc;

    // Opcode zero marks a slot with no control transfer
    always_ff @(posedge clk) begin
        if (reset || bubble_i || mispredict_o) begin
            opcodeE    <= '0;
            predTakenE <= 1'b0;
        end else begin
            opcodeE    <= opcode_i;
            predTakenE <= predTaken_i;
        end
    end

    always_ff @(posedge clk) begin
        funct3E   <= funct3_i;
        immE      <= imm_i;
        pcE       <= pc_i;
        phtIndexE <= phtIndex_i;
    end

    assign isBranch = (opcodeE == OP_BRANCH);
    assign isJal    = (opcodeE == OP_JAL);

    assign branchTaken = (funct3E == F3_BEQ && zero_i) ||
                         (funct3E == F3_BNE && !zero_i);

    assign targetPc = pcE + immE;

    assign mispredict_o = (isBranch && (predTakenE != branchTaken)) ||
                          (isJal && !predTakenE);

    // Undo whichever path fetch followed
    assign redirectPc_o = predTakenE ? pcE + INSTR_BYTES : targetPc;

    assign btbWe_o     = isJal || (isBranch && branchTaken);
    assign btbPc_o     = pcE;
    assign btbTarget_o = targetPc;
    assign btbJump_o   = isJal;

    assign phtWe_o    = isBranch;
    assign phtIndex_o = phtIndexE;
    assign phtTaken_o = branchTaken;

    // Fetch only ever steps in whole words
    aRedirectAligned : assert property (@(posedge clk) disable iff (reset)
        mispredict_o |-> (redirectPc_o[1:0] == 2'b00));

endmodule

// ==== verilog/branchFrontEnd.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch prediction front end top
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module branchFrontEnd #(
    parameter branchPkg::addrT RESET_PC    = '0,
    parameter int              BTB_ENTRIES = 32,
    parameter int              GHR_BITS    = 5
) (
    input  logic             clk,
    input  logic             reset,
    input  branchPkg::instrT instrF_i,
    input  logic             stall_i,
    input  logic             zeroE_i,
    output branchPkg::addrT  pcF_o,
    output logic             predictTakenF_o,
    output logic             mispredictE_o
);

    import branchPkg::*;

    logic                btbHitF;
    addrT                btbTargetF;
    logic                btbJumpF;
    logic [GHR_BITS-1:0] phtIndexF;
    counterT             counterF;
    logic                historyShift;

    opcodeT              opcodeD;
    funct3T              funct3D;
    addrT                immD;
    addrT                pcD;
    logic                predTakenD;
    logic [GHR_BITS-1:0] phtIndexD;

    addrT                redirectPcE;
    logic                btbWeE;
    addrT                btbPcE;
    addrT                btbTargetE;
    logic                btbJumpE;
    logic                phtWeE;
    logic [GHR_BITS-1:0] phtIndexE;
    logic                phtTakenE;

    // Jumps in the BTB are always taken, branches follow the counter
    assign predictTakenF_o = btbHitF && (btbJumpF || counterF[1]);

    assign historyShift = !stall_i && !mispredictE_o && (instrF_i[6:0] == OP_BRANCH);

    fetchStage #(.RESET_PC(RESET_PC)) i_fetchStage (
        .clk(clk), .reset(reset), .stall_i(stall_i),
        .mispredict_i(mispredictE_o), .redirectPc_i(redirectPcE),
        .predictTaken_i(predictTakenF_o), .predictTarget_i(btbTargetF),
        .pc_o(pcF_o)
    );

    branchTargetBuffer #(.BTB_ENTRIES(BTB_ENTRIES)) i_branchTargetBuffer (
        .clk(clk), .reset(reset), .lookupPc_i(pcF_o),
        .hit_o(btbHitF), .target_o(btbTargetF), .isJump_o(btbJumpF),
        .we_i(btbWeE), .writePc_i(btbPcE), .writeTarget_i(btbTargetE),
        .writeJump_i(btbJumpE)
    );

    gshareTable #(.GHR_BITS(GHR_BITS)) i_gshareTable (
        .clk(clk), .reset(reset), .fetchPc_i(pcF_o),
        .readIndex_o(phtIndexF), .counter_o(counterF),
        .shiftEn_i(historyShift), .shiftBit_i(predictTakenF_o),
        .clearHistory_i(mispredictE_o), .updateEn_i(phtWeE),
        .updateIndex_i(phtIndexE), .taken_i(phtTakenE)
    );

    decodeStage #(.GHR_BITS(GHR_BITS)) i_decodeStage (
        .clk(clk), .reset(reset), .stall_i(stall_i), .flush_i(mispredictE_o),
        .instr_i(instrF_i), .pc_i(pcF_o), .predTaken_i(predictTakenF_o),
        .phtIndex_i(phtIndexF), .opcode_o(opcodeD), .funct3_o(funct3D),
        .imm_o(immD), .pc_o(pcD), .predTaken_o(predTakenD), .phtIndex_o(phtIndexD)
    );

    branchResolve #(.BTB_ENTRIES(BTB_ENTRIES), .GHR_BITS(GHR_BITS)) i_branchResolve (
        .clk(clk), .reset(reset), .bubble_i(stall_i),
        .opcode_i(opcodeD), .funct3_i(funct3D), .imm_i(immD), .pc_i(pcD),
        .predTaken_i(predTakenD), .phtIndex_i(phtIndexD), .zero_i(zeroE_i),
        .mispredict_o(mispredictE_o), .redirectPc_o(redirectPcE),
        .btbWe_o(btbWeE), .btbPc_o(btbPcE), .btbTarget_o(btbTargetE),
        .btbJump_o(btbJumpE), .phtWe_o(phtWeE), .phtIndex_o(phtIndexE),
        .phtTaken_o(phtTakenE)
    );

endmodule

// ==== sim/tbBranchFrontEnd.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the branch front end,
// with instruction memory model and directed tests
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tbBranchFrontEnd;

    import branchPkg::*;

    localparam addrT RESET_PC  = 32'd0;
    localparam int   NUM_TESTS = 5;
    localparam int   MEM_WORDS = 256;

    logic  clk;
    logic  reset;
    instrT instrF;
    logic  stall;
    logic  zeroE;
    addrT  pcF;
    logic  predictTakenF;
    logic  mispredictE;

    // Instruction memory and the zero flag each word produces in execute
    instrT imem [MEM_WORDS];
    logic  zeroMem [MEM_WORDS];

    logic        holdReset;
    logic [31:0] rngState;
    int          errorCount;
    int          checkCount;

    // PCs of the words now in decode and execute, as seen by the model
    addrT fetchPc;
    addrT decPc;
    addrT execPc;

    branchFrontEnd #(
        .RESET_PC(RESET_PC),
        .BTB_ENTRIES(32),
        .GHR_BITS(5)
    ) i_branchFrontEnd (
        .clk(clk), .reset(reset), .instrF_i(instrF), .stall_i(stall),
        .zeroE_i(zeroE), .pcF_o(pcF), .predictTakenF_o(predictTakenF),
        .mispredictE_o(mispredictE)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        $display("Watchdog timeout, the directed tests did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Forward byte offset between 16 and 76
    function automatic addrT pickOffset();
        rngState = xorshift32(rngState);
        return ((rngState % 16) + 4) * 4;
    endfunction

    function automatic instrT encodeBranch(input funct3T f3, input addrT imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic instrT encodeJal(input addrT imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OP_JAL};
    endfunction

    task automatic checkAddr(input string name, input addrT expected, input addrT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // R-type filler, never a control transfer
    task automatic loadFiller();
        for (int i = 0; i < MEM_WORDS; i++) begin
            rngState = xorshift32(rngState);
            imem[i] = {rngState[31:7], 7'b0110011};
            zeroMem[i] = 1'b0;
        end
    endtask

    // Drive 1 unit after the edge, return at the falling edge for sampling
    task automatic stepCycle(input logic stallNext);
        @(posedge clk);
        #1;
        if (!stall) begin
            execPc = decPc;
            decPc = fetchPc;
        end
        fetchPc = pcF;
        reset = holdReset;
        stall = stallNext;
        instrF = imem[pcF[9:2]];
        zeroE = zeroMem[execPc[9:2]];
        @(negedge clk);
    endtask

    task automatic resetDut();
        holdReset = 1'b1;
        repeat (10) stepCycle(1'b0);
        holdReset = 1'b0;
        stepCycle(1'b0);
    endtask

    task automatic stepToPc(input string name, input addrT target);
        int steps;
        steps = 0;
        while (pcF !== target && steps < 64) begin
            stepCycle(1'b0);
            steps++;
        end
        if (pcF !== target) begin
            errorCount++;
            $display("%s: fetch never reached PC %h", name, target);
        end
    endtask

    // beq at branchPc jumps forward, the jal there jumps back to it
    task automatic placeLoop(input addrT branchPc, input addrT off);
        addrT loopEnd;
        loopEnd = branchPc + off;
        imem[branchPc[9:2]] = encodeBranch(F3_BEQ, off);
        imem[loopEnd[9:2]] = encodeJal(-off);
        zeroMem[branchPc[9:2]] = 1'b1;
    endtask

    // Untrained pass, both control transfers miss; ends with P fetched again
    task automatic firstPass(input string name, input addrT branchPc, input addrT off);
        stepToPc(name, branchPc);
        repeat (2) stepCycle(1'b0);
        checkBit({name, " beq mispredict"}, 1'b1, mispredictE);
        stepCycle(1'b0);
        checkAddr({name, " beq target"}, branchPc + off, pcF);
        repeat (2) stepCycle(1'b0);
        checkBit({name, " jal mispredict"}, 1'b1, mispredictE);
        stepCycle(1'b0);
        checkAddr({name, " jal target"}, branchPc, pcF);
    endtask

    task automatic sequentialFetch();
        loadFiller();
        resetDut();
        checkAddr("seq reset pc", RESET_PC, pcF);
        for (int i = 1; i <= 4; i++) begin
            stepCycle(1'b0);
            checkAddr("seq step", RESET_PC + 4 * i, pcF);
        end
        stepCycle(1'b1);
        checkAddr("seq stall start", RESET_PC + 20, pcF);
        repeat (2) begin
            stepCycle(1'b1);
            checkAddr("seq stall hold", RESET_PC + 20, pcF);
        end
        stepCycle(1'b0);
        checkAddr("seq stall last", RESET_PC + 20, pcF);
        stepCycle(1'b0);
        checkAddr("seq resume", RESET_PC + 24, pcF);
        checkBit("seq no mispredict", 1'b0, mispredictE);
    endtask

    task automatic coldTakenBeq();
        addrT branchPc;
        addrT off;
        branchPc = 32'd16;
        off = pickOffset();
        loadFiller();
        imem[branchPc[9:2]] = encodeBranch(F3_BEQ, off);
        zeroMem[branchPc[9:2]] = 1'b1;
        resetDut();
        stepToPc("cold", branchPc);
        checkBit("cold predict", 1'b0, predictTakenF);
        stepCycle(1'b0);
        checkBit("cold decode", 1'b0, mispredictE);
        stepCycle(1'b0);
        checkBit("cold mispredict", 1'b1, mispredictE);
        stepCycle(1'b0);
        checkAddr("cold redirect", branchPc + off, pcF);
    endtask

    task automatic correctNotTakenBne();
        addrT branchPc;
        branchPc = 32'd20;
        loadFiller();
        imem[branchPc[9:2]] = encodeBranch(F3_BNE, pickOffset());
        zeroMem[branchPc[9:2]] = 1'b1;
        resetDut();
        stepToPc("bne", branchPc);
        checkBit("bne predict", 1'b0, predictTakenF);
        for (int i = 1; i <= 3; i++) begin
            stepCycle(1'b0);
            checkBit("bne mispredict", 1'b0, mispredictE);
            checkAddr("bne sequential", branchPc + 4 * i, pcF);
        end
    endtask

    task automatic trainedLoop();
        addrT branchPc;
        addrT off;
        branchPc = 32'd12;
        off = pickOffset();
        loadFiller();
        placeLoop(branchPc, off);
        resetDut();
        firstPass("loop", branchPc, off);
        checkBit("loop beq predict", 1'b1, predictTakenF);
        stepCycle(1'b0);
        checkAddr("loop predicted target", branchPc + off, pcF);
        checkBit("loop jal predict", 1'b1, predictTakenF);
        stepCycle(1'b0);
        checkAddr("loop predicted back", branchPc, pcF);
        checkBit("loop beq resolve", 1'b0, mispredictE);
        stepCycle(1'b0);
        checkBit("loop jal resolve", 1'b0, mispredictE);
    endtask

    task automatic takenFallThrough();
        addrT branchPc;
        addrT off;
        branchPc = 32'd40;
        off = pickOffset();
        loadFiller();
        placeLoop(branchPc, off);
        resetDut();
        firstPass("fall", branchPc, off);
        // The second pass of the beq falls through
        zeroMem[branchPc[9:2]] = 1'b0;
        checkBit("fall predict", 1'b1, predictTakenF);
        stepCycle(1'b0);
        checkAddr("fall predicted target", branchPc + off, pcF);
        stepCycle(1'b0);
        checkBit("fall mispredict", 1'b1, mispredictE);
        stepCycle(1'b0);
        checkAddr("fall redirect", branchPc + 4, pcF);
    endtask

    initial begin
        reset = 1'b1;
        stall = 1'b0;
        zeroE = 1'b0;
        instrF = NOP_INSTR;
        holdReset = 1'b1;
        rngState = 32'd78869;
        errorCount = 0;
        checkCount = 0;
        fetchPc = '0;
        decPc = '0;
        execPc = '0;
        sequentialFetch();
        coldTakenBeq();
        correctNotTakenBne();
        trainedLoop();
        takenFallThrough();
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/branchPkg.sv
verilog/branchTargetBuffer.sv
verilog/gshareTable.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/branchResolve.sv
verilog/branchFrontEnd.sv
sim/tbBranchFrontEnd.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tbBranchFrontEnd
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(SIM_LOG) 2>&1
	@cat $(SIM_LOG)
	@if grep -q "Simulation FAILED" $(SIM_LOG); then echo "Run failed"; exit 1; fi
	@grep -q "Simulation PASSED" $(SIM_LOG) || { echo "Run ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
